// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
TOP       ?= bch_decode_tb
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// ==== filelist.f ====
+incdir+rtl
rtl/bch_pkg.sv
rtl/bch_step_counter.sv
rtl/bch_ctrl.sv
rtl/bch_syndrome.sv
rtl/bch_key.sv
rtl/bch_chien.sv
rtl/bch_decode_top.sv
test/bch_decode_sva.sv
test/bch_decode_tb.sv

// ==== rtl/bch_chien.sv ====
`timescale 1ns/1ps

`include "bch_consts.svh"

module bch_chien (
	input logic clk,
	input logic reset,
	input logic start,
	input logic step,
	input bch_pkg::bch_in_t word,
	input bch_pkg::sigma_t sigma,
	input logic [1:0] degree,
	output bch_pkg::bch_out_t result
);

	bch_pkg::gf_elem_t term [0:`BCH_T];
	bch_pkg::gf_elem_t term_next [0:`BCH_T];
	bch_pkg::gf_elem_t sig [0:`BCH_T];
	bch_pkg::gf_elem_t eval;
	logic [`BCH_N-1:0] cw;
	logic [1:0] count;
	logic first;
	logic root;

	assign sig[0] = sigma.sig0;
	assign sig[1] = sigma.sig1;
	assign sig[2] = sigma.sig2;

	// Step n tests position 14-n, that is sigma(alpha^(n+1)).
	always_comb begin
		bch_pkg::gf_elem_t apow;
		apow = bch_pkg::gf_elem_t'(1);
		eval = '0;
		for (int j = 0; j <= `BCH_T; j++) begin
			term_next[j] = bch_pkg::gf_mul(first ? sig[j] : term[j], apow);
			eval = eval ^ term_next[j];
			apow = bch_pkg::gf_mul(apow, bch_pkg::gf_elem_t'(2));
		end
	end

	assign root = eval == '0;

	always_ff @(posedge clk) begin
		if (reset) begin
			first <= 1'b1;
			count <= '0;
		end else if (start) begin
			first <= 1'b1;
			count <= '0;
		end else if (step) begin
			first <= 1'b0;
			if (root)
				count <= count + 2'd1;
		end
	end

	// The word rotates once around, so it is back in place after 15 steps.
	always_ff @(posedge clk) begin
		if (start) begin
			cw <= word.bits;
		end else if (step) begin
			cw <= {cw[`BCH_N-2:0], cw[`BCH_N-1] ^ root};
			term <= term_next;
		end
	end

	assign result.data = cw[`BCH_N-1 -: `BCH_K];
	assign result.err_count = count;
	assign result.uncorrectable = count != degree;

endmodule

// ==== rtl/bch_consts.svh ====
`ifndef BCH_CONSTS_SVH
`define BCH_CONSTS_SVH

// ======================================================================
// BCH(15,7) code over GF(2^4), t = 2
// ======================================================================

`define BCH_M 4
`define BCH_T 2
`define BCH_N 15
`define BCH_K 7

`define BCH_POLY 5'b10011	// Field polynomial x^4 + x + 1.

`endif

// ==== rtl/bch_ctrl.sv ====
`timescale 1ns/1ps

`include "bch_consts.svh"

module bch_ctrl (
	input logic clk,
	input logic reset,
	input logic in_valid,
	output logic in_ready,
	output logic out_valid,
	input logic out_ready,
	input logic last,
	output logic load,
	output logic [3:0] load_value,
	output logic synd_step,
	output logic key_step,
	output logic chien_step,
	output logic start
);

	bch_pkg::dec_state_t state;
	logic valid_q;
	logic accept;

	assign accept = in_valid && in_ready;

	// ==================================================================
	// Phase sequencing
	// ==================================================================

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= bch_pkg::IDLE;
			valid_q <= 1'b0;
		end else begin
			case (state)
				bch_pkg::IDLE: if (accept) state <= bch_pkg::SYND;
				bch_pkg::SYND: if (last) state <= bch_pkg::KEY;
				bch_pkg::KEY: if (last) state <= bch_pkg::CHIEN;
				bch_pkg::CHIEN: if (last) state <= bch_pkg::DONE;
				bch_pkg::DONE: begin
					if (!valid_q) begin
						valid_q <= 1'b1;	// Result settles one cycle first.
					end else if (out_ready) begin
						valid_q <= 1'b0;
						state <= bch_pkg::IDLE;
					end
				end
				default: state <= bch_pkg::IDLE;
			endcase
		end
	end

	assign in_ready = state == bch_pkg::IDLE;
	assign out_valid = valid_q;

	assign synd_step = state == bch_pkg::SYND;
	assign key_step = state == bch_pkg::KEY;
	assign chien_step = state == bch_pkg::CHIEN;

	assign start = accept;	// All data blocks clear when a word is taken.
	assign load = accept || (last && (synd_step || key_step));
	assign load_value = synd_step ? 4'(`BCH_T) : 4'(`BCH_N);

endmodule

// ==== rtl/bch_decode_top.sv ====
`timescale 1ns/1ps

module bch_decode_top (
	input logic clk,
	input logic reset,
	input logic in_valid,
	output logic in_ready,
	input bch_pkg::bch_in_t in_word,
	output logic out_valid,
	input logic out_ready,
	output bch_pkg::bch_out_t out_result
);

	logic last;
	logic load;
	logic [3:0] load_value;
	logic synd_step;
	logic key_step;
	logic chien_step;
	logic phase_step;
	logic start;
	bch_pkg::syndromes_t syndromes;
	bch_pkg::sigma_t sigma;
	logic [1:0] degree;

	assign phase_step = synd_step || key_step || chien_step;

	bch_ctrl u_ctrl (
		.clk(clk),
		.reset(reset),
		.in_valid(in_valid),
		.in_ready(in_ready),
		.out_valid(out_valid),
		.out_ready(out_ready),
		.last(last),
		.load(load),
		.load_value(load_value),
		.synd_step(synd_step),
		.key_step(key_step),
		.chien_step(chien_step),
		.start(start)
	);

	bch_step_counter u_counter (
		.clk(clk),
		.reset(reset),
		.load(load),
		.load_value(load_value),
		.step(phase_step),
		.last(last)
	);

	bch_syndrome u_syndrome (
		.clk(clk),
		.reset(reset),
		.start(start),
		.step(synd_step),
		.word(in_word),
		.syndromes(syndromes)
	);

	bch_key u_key (
		.clk(clk),
		.reset(reset),
		.start(start),
		.step(key_step),
		.syndromes(syndromes),
		.sigma(sigma),
		.degree(degree)
	);

	bch_chien u_chien (
		.clk(clk),
		.reset(reset),
		.start(start),
		.step(chien_step),
		.word(in_word),
		.sigma(sigma),
		.degree(degree),
		.result(out_result)
	);

endmodule

// ==== rtl/bch_key.sv ====
`timescale 1ns/1ps

`include "bch_consts.svh"

module bch_key (
	input logic clk,
	input logic reset,
	input logic start,
	input logic step,
	input bch_pkg::syndromes_t syndromes,
	output bch_pkg::sigma_t sigma,
	output logic [1:0] degree
);

	bch_pkg::gf_elem_t lambda [0:`BCH_T];
	bch_pkg::gf_elem_t b_poly [0:`BCH_T];
	bch_pkg::gf_elem_t lambda_next [0:`BCH_T];
	bch_pkg::gf_elem_t s [1:2*`BCH_T];
	bch_pkg::gf_elem_t gamma;
	bch_pkg::gf_elem_t delta;
	logic [$clog2(`BCH_T)-1:0] iter;
	logic signed [3:0] k;
	logic [1:0] l;
	logic swap;

	assign s[1] = syndromes.s1;
	assign s[2] = syndromes.s2;
	assign s[3] = syndromes.s3;
	assign s[4] = syndromes.s4;

	// ==================================================================
	// Discrepancy and locator update, inversionless binary form
	// ==================================================================

	always_comb begin
		int idx;
		delta = '0;
		for (int j = 0; j <= `BCH_T; j++) begin
			idx = 2 * int'(iter) + 1 - j;
			if (idx >= 1 && idx <= 2 * `BCH_T)
				delta = delta ^ bch_pkg::gf_mul(lambda[j], s[idx]);
		end
		lambda_next[0] = bch_pkg::gf_mul(gamma, lambda[0]);
		for (int j = 1; j <= `BCH_T; j++)
			lambda_next[j] = bch_pkg::gf_mul(gamma, lambda[j]) ^
				bch_pkg::gf_mul(delta, b_poly[j-1]);
	end

	assign swap = delta != '0 && k >= 0;	// Length change this iteration.

	always_ff @(posedge clk) begin
		if (reset) begin
			iter <= '0;
			k <= '0;
			l <= '0;
		end else if (start) begin
			iter <= '0;
			k <= '0;
			l <= '0;
		end else if (step) begin
			iter <= iter + 1'b1;
			if (swap) begin
				k <= -k;
				l <= 2'(2 * int'(iter) + 1) - l;
			end else begin
				k <= k + 4'sd2;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			for (int j = 0; j <= `BCH_T; j++) begin
				lambda[j] <= (j == 0) ? bch_pkg::gf_elem_t'(1) : '0;
				b_poly[j] <= (j == 0) ? bch_pkg::gf_elem_t'(1) : '0;
			end
			gamma <= bch_pkg::gf_elem_t'(1);
		end else if (step) begin
			lambda <= lambda_next;
			b_poly[0] <= '0;
			if (swap) begin
				for (int j = 1; j <= `BCH_T; j++)
					b_poly[j] <= lambda[j-1];	// B becomes x * lambda.
				gamma <= delta;
			end else begin
				b_poly[1] <= '0;
				for (int j = 2; j <= `BCH_T; j++)
					b_poly[j] <= b_poly[j-2];
			end
		end
	end

	assign sigma.sig0 = lambda[0];
	assign sigma.sig1 = lambda[1];
	assign sigma.sig2 = lambda[2];
	assign degree = l;

endmodule

// ==== rtl/bch_pkg.sv ====
`include "bch_consts.svh"

package bch_pkg;

	localparam logic [`BCH_M:0] POLY = `BCH_POLY;

	typedef logic [`BCH_M-1:0] gf_elem_t;

	typedef struct packed {
		gf_elem_t s4;
		gf_elem_t s3;
		gf_elem_t s2;
		gf_elem_t s1;
	} syndromes_t;

	typedef struct packed {
		gf_elem_t sig2;
		gf_elem_t sig1;
		gf_elem_t sig0;
	} sigma_t;

	typedef struct packed {
		logic [`BCH_N-1:0] bits;	// Bit 14 is the first bit sent.
	} bch_in_t;

	typedef struct packed {
		logic [`BCH_K-1:0] data;
		logic [1:0] err_count;
		logic uncorrectable;
	} bch_out_t;

	typedef enum logic [2:0] {IDLE, SYND, KEY, CHIEN, DONE} dec_state_t;

	// Shift-and-add multiply, reducing by the field polynomial each shift.
	function automatic gf_elem_t gf_mul(gf_elem_t a, gf_elem_t b);
		gf_elem_t acc;
		gf_elem_t sh;
		acc = '0;
		sh = a;
		for (int i = 0; i < `BCH_M; i++) begin
			if (b[i])
				acc = acc ^ sh;
			if (sh[`BCH_M-1])
				sh = (sh << 1) ^ POLY[`BCH_M-1:0];
			else
				sh = sh << 1;
		end
		return acc;
	endfunction

endpackage

// ==== rtl/bch_step_counter.sv ====
`timescale 1ns/1ps

module bch_step_counter (
	input logic clk,
	input logic reset,
	input logic load,
	input logic [3:0] load_value,
	input logic step,
	output logic last
);

	logic [3:0] count;

	always_ff @(posedge clk) begin
		if (reset) begin
			count <= '0;
		end else if (load) begin
			count <= load_value;
		end else if (step && count != 4'd0) begin
			count <= count - 4'd1;
		end
	end

	assign last = step && count == 4'd1;	// Final step of the phase.

endmodule

// ==== rtl/bch_syndrome.sv ====
`timescale 1ns/1ps

`include "bch_consts.svh"

module bch_syndrome (
	input logic clk,
	input logic reset,
	input logic start,
	input logic step,
	input bch_pkg::bch_in_t word,
	output bch_pkg::syndromes_t syndromes
);

	logic [`BCH_N-1:0] shreg;
	bch_pkg::gf_elem_t s [1:2*`BCH_T];
	bch_pkg::gf_elem_t s_next [1:2*`BCH_T];

	// Horner step: S_i <= S_i * alpha^i + r_j, highest bit first.
	always_comb begin
		bch_pkg::gf_elem_t apow;
		apow = bch_pkg::gf_elem_t'(1);
		for (int i = 1; i <= 2 * `BCH_T; i++) begin
			apow = bch_pkg::gf_mul(apow, bch_pkg::gf_elem_t'(2));
			s_next[i] = bch_pkg::gf_mul(s[i], apow);
			s_next[i][0] = s_next[i][0] ^ shreg[`BCH_N-1];
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 1; i <= 2 * `BCH_T; i++)
				s[i] <= '0;
		end else if (start) begin
			for (int i = 1; i <= 2 * `BCH_T; i++)
				s[i] <= '0;
		end else if (step) begin
			for (int i = 1; i <= 2 * `BCH_T; i++)
				s[i] <= s_next[i];
		end
	end

	always_ff @(posedge clk) begin
		if (start)
			shreg <= word.bits;
		else if (step)
			shreg <= {shreg[`BCH_N-2:0], 1'b0};
	end

	assign syndromes.s1 = s[1];
	assign syndromes.s2 = s[2];
	assign syndromes.s3 = s[3];
	assign syndromes.s4 = s[4];

endmodule

// ==== test/bch_decode_sva.sv ====
`timescale 1ns/1ps

module bch_decode_sva (
	input logic clk,
	input logic reset,
	input logic in_ready,
	input logic out_valid,
	input logic out_ready,
	input bch_pkg::bch_out_t out_result
);

	// ==================================================================
	// Handshake rules
	// ==================================================================

	assert property (@(posedge clk) disable iff (reset)
		out_valid && !out_ready |=> out_valid && $stable(out_result))
		else $error("Output changed while out_ready was low");

	assert property (@(posedge clk) disable iff (reset) !(in_ready && out_valid))
		else $error("in_ready and out_valid were high in the same cycle");

	assert property (@(posedge clk) reset |=> !out_valid)
		else $error("out_valid was high in the cycle after reset");

endmodule

bind bch_decode_top bch_decode_sva u_sva (
	.clk(clk),
	.reset(reset),
	.in_ready(in_ready),
	.out_valid(out_valid),
	.out_ready(out_ready),
	.out_result(out_result)
);

// ==== test/bch_decode_tb.sv ====
`timescale 1ns/1ps

`include "bch_consts.svh"

module bch_decode_tb;

	localparam int NUM_WORDS = 78;	// 20 + 20 + 20 + 10 + 8 codewords.
	localparam int TIMEOUT_CYCLES = NUM_WORDS * 40 + 100;
	localparam logic [8:0] GEN_POLY = 9'b111010001;	// x^8+x^7+x^6+x^4+1.

	logic clk = 1'b0;
	logic reset;
	logic in_valid;
	logic in_ready;
	bch_pkg::bch_in_t in_word;
	logic out_valid;
	logic out_ready;
	bch_pkg::bch_out_t out_result;

	integer seed = 32'hbfc7abf6;
	int cycles = 0;
	int accept_cycle = 0;

	bch_decode_top UUT (
		.clk(clk),
		.reset(reset),
		.in_valid(in_valid),
		.in_ready(in_ready),
		.in_word(in_word),
		.out_valid(out_valid),
		.out_ready(out_ready),
		.out_result(out_result)
	);

	always #50 clk = ~clk;

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("Timeout after %0d cycles, the decoder stopped responding", cycles);
			$display("Something failed");
			$fatal(1, "Run stopped at the cycle limit");
		end
	end

	// ==================================================================
	// Reference encoder and helpers
	// ==================================================================

	function automatic logic [`BCH_N-1:0] encode_word(input logic [`BCH_K-1:0] data);
		logic [`BCH_N-1:0] rem;
		rem = {data, 8'd0};
		for (int i = `BCH_N - 1; i >= 8; i--) begin
			if (rem[i])
				rem = rem ^ (15'(GEN_POLY) << (i - 8));	// Long division step.
		end
		return {data, rem[7:0]};
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			$display("MISMATCH at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
			$display("Something failed");
			$fatal(1, "Value check failed");
		end
	endtask

	task automatic send_word(input logic [`BCH_N-1:0] word);
		@(posedge clk);
		in_valid <= 1'b1;
		in_word.bits <= word;
		do @(negedge clk); while (!in_ready);
		@(posedge clk);	// Accept edge.
		in_valid <= 1'b0;
		@(negedge clk);
		accept_cycle = cycles;
		check_value("in_ready", 32'(in_ready), 32'd0);
	endtask

	task automatic receive_result(input logic [`BCH_K-1:0] exp_data,
			input logic [1:0] exp_count, input int hold);
		logic [9:0] held;
		do @(negedge clk); while (!out_valid);
		check_value("latency", 32'(cycles - accept_cycle), 32'd33);
		check_value("out_result.data", 32'(out_result.data), 32'(exp_data));
		check_value("out_result.err_count", 32'(out_result.err_count), 32'(exp_count));
		check_value("out_result.uncorrectable", 32'(out_result.uncorrectable), 32'd0);
		held = out_result;
		for (int i = 0; i < hold; i++) begin
			@(posedge clk);
			if (i == hold - 1)
				out_ready <= 1'b1;	// Last stalled edge.
			@(negedge clk);
			check_value("out_valid", 32'(out_valid), 32'd1);
			check_value("out_result", 32'(out_result), 32'(held));
			check_value("in_ready", 32'(in_ready), 32'd0);
		end
		@(posedge clk);	// Output transfer.
		@(negedge clk);
		check_value("in_ready", 32'(in_ready), 32'd1);
		check_value("out_valid", 32'(out_valid), 32'd0);
	endtask

	task automatic decode_one(input int n_err, input bit stall);
		logic [`BCH_K-1:0] data;
		logic [`BCH_N-1:0] word;
		int p1;
		int p2;
		int hold;
		data = 7'($random(seed));
		p1 = int'($unsigned($random(seed)) % 15);
		p2 = (p1 + 1 + int'($unsigned($random(seed)) % 14)) % 15;	// Never equal to p1.
		hold = stall ? int'($unsigned($random(seed)) % 11) : 0;
		word = encode_word(data);
		if (n_err > 0)
			word[p1] = ~word[p1];
		if (n_err > 1)
			word[p2] = ~word[p2];
		send_word(word);
		if (hold > 0) begin
			@(posedge clk);
			out_ready <= 1'b0;
		end
		receive_result(data, 2'(n_err), hold);
	endtask

	// ==================================================================
	// Directed tests
	// ==================================================================

	task automatic idle_after_reset();
		@(negedge clk);
		check_value("in_ready", 32'(in_ready), 32'd1);
		check_value("out_valid", 32'(out_valid), 32'd0);
	endtask

	task automatic clean_words();
		for (int i = 0; i < 20; i++)
			decode_one(0, 1'b0);
	endtask

	task automatic single_bit_errors();
		for (int i = 0; i < 20; i++)
			decode_one(1, 1'b0);
	endtask

	task automatic double_bit_errors();
		for (int i = 0; i < 20; i++)
			decode_one(2, 1'b0);
	endtask

	task automatic stalled_output();
		for (int i = 0; i < 10; i++)
			decode_one(i % 3, 1'b1);
	endtask

	task automatic back_to_back_words();
		logic [`BCH_K-1:0] data [8];
		logic [`BCH_N-1:0] words [8];
		for (int i = 0; i < 8; i++) begin
			data[i] = 7'($random(seed));
			words[i] = encode_word(data[i]) ^ (15'(i % 2) << ($unsigned($random(seed)) % 15));
		end
		fork
			for (int i = 0; i < 8; i++)
				send_word(words[i]);
			for (int i = 0; i < 8; i++)
				receive_result(data[i], 2'(i % 2), 0);	// Results come back in order.
		join
	endtask

	initial begin
		reset = 1'b1;
		in_valid = 1'b0;
		in_word = '0;
		out_ready = 1'b1;
		repeat (2) @(posedge clk);
		reset <= 1'b0;
		idle_after_reset();
		clean_words();
		single_bit_errors();
		double_bit_errors();
		stalled_output();
		back_to_back_words();
		$display("Everything OK");
		$finish;
	end

endmodule
